// File: sources.f
+incdir+src
src/rvc_pkg.sv
src/rvc_classify.sv
src/rvc_expand.sv
src/rv_field_decode.sv
src/rvc_frontend.sv
tb/rvc_frontend_assert.sv
tb/rvc_frontend_tb.sv

// File: Bender.yml
package:
  name: rvc_frontend

sources:
  - include_dirs:
      - src
    files:
      - src/rvc_pkg.sv
      - src/rvc_classify.sv
      - src/rvc_expand.sv
      - src/rv_field_decode.sv
      - src/rvc_frontend.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/rvc_frontend_assert.sv
      - tb/rvc_frontend_tb.sv

// File: tb/rvc_frontend_tb.sv
// Testbench for the RVC front end, random fetch windows checked against a reference model
`timescale 1ns/1ns
`include "rvc_config.svh"

module rvc_frontend_tb import rvc_pkg::*; ();

    localparam int NUM_WIN = 2000;
    localparam int TIMEOUT = 32;
    localparam logic [6:0] LEGAL_OPS [10] = '{OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP,
        OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_SYSTEM};

    logic        clk;
    logic        rst_n;
    logic        win_valid;
    fetch_win_t  win;
    logic        dec_valid;
    decoded_t    dec;
    logic [31:0] next_pc;

    logic [31:0] lfsr;
    // Expected outputs in window order
    decoded_t    exp_q[$];

    rvc_frontend DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .win_valid (win_valid),
        .win       (win),
        .dec_valid (dec_valid),
        .dec       (dec),
        .next_pc   (next_pc)
    );

    // Galois LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // RVC primed registers are x8..x15
    function automatic logic [4:0] prime_reg(input logic [2:0] r);
        return {2'b01, r};
    endfunction

    function automatic logic [31:0] i_type(input logic [31:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] sw_word(input logic [31:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    // Branch against x0
    function automatic logic [31:0] b_type(input logic [31:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd0, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [31:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    // Reference RV32C expansion from the ISA tables
    function automatic expanded_t model_expand(input logic [31:0] instr,
                                               input logic [31:0] pc);
        expanded_t   e;
        logic [15:0] c;
        logic [4:0]  rd;
        logic [4:0]  rdp;
        logic [4:0]  rsp;
        logic [31:0] nzi;
        logic [31:0] imm;
        logic [31:0] jimm;
        logic [31:0] bimm;
        c    = instr[15:0];
        rd   = c[11:7];
        rdp  = prime_reg(c[4:2]);
        rsp  = prime_reg(c[9:7]);
        nzi  = {{26{c[12]}}, c[12], c[6:2]};
        jimm = {{20{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
        bimm = {{23{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};
        e.pc         = pc;
        e.compressed = (c[1:0] != 2'b11);
        e.incr       = e.compressed ? 3'd2 : 3'd4;
        e.instr      = instr;
        e.illegal    = e.compressed && !`RVC_HAS_C;
        if (e.compressed && `RVC_HAS_C) begin
            e.instr = '0;
            case ({c[1:0], c[15:13]})
                // C.ADDI4SPN
                5'b00_000: begin
                    imm       = {22'd0, c[10:7], c[12:11], c[5], c[6], 2'b00};
                    e.instr   = i_type(imm, 5'd2, 3'b000, rdp, OPC_OP_IMM);
                    e.illegal = (imm == 0);
                end
                5'b00_010: e.instr = i_type({25'd0, c[5], c[12:10], c[6], 2'b00}, rsp,
                                            3'b010, rdp, OPC_LOAD);
                5'b00_110: e.instr = sw_word({25'd0, c[5], c[12:10], c[6], 2'b00}, rdp, rsp);
                5'b01_000: e.instr = i_type(nzi, rd, 3'b000, rd, OPC_OP_IMM);
                5'b01_001: e.instr = j_type(jimm, 5'd1);
                5'b01_010: e.instr = i_type(nzi, 5'd0, 3'b000, rd, OPC_OP_IMM);
                5'b01_011: begin
                    if (rd == 5'd2) begin
                        // Stack pointer adjust in 16-byte steps
                        imm     = {{22{c[12]}}, c[12], c[4:3], c[5], c[2], c[6], 4'b0000};
                        e.instr = i_type(imm, 5'd2, 3'b000, 5'd2, OPC_OP_IMM);
                    end else begin
                        imm     = nzi;
                        e.instr = {nzi[19:0], rd, OPC_LUI};
                    end
                    e.illegal = (imm == 0);
                end
                5'b01_100: begin
                    case (c[11:10])
                        2'b00: e.instr = i_type({27'd0, c[6:2]}, rsp, 3'b101, rsp, OPC_OP_IMM);
                        2'b01: e.instr = i_type({20'd0, 7'b0100000, c[6:2]}, rsp, 3'b101, rsp,
                                                OPC_OP_IMM);
                        2'b10: e.instr = i_type(nzi, rsp, 3'b111, rsp, OPC_OP_IMM);
                        // SUB XOR OR AND, funct3 000 100 110 111
                        default: e.instr = r_type((c[6:5] == 2'b00) ? 7'b0100000 : 7'b0, rdp,
                                                  rsp, {c[6] | c[5], c[6], c[6] & c[5]}, rsp);
                    endcase
                    // shamt[5] and the RV64 word ops
                    e.illegal = c[12] && (c[11:10] != 2'b10);
                end
                5'b01_101: e.instr = j_type(jimm, 5'd0);
                5'b01_110: e.instr = b_type(bimm, rsp, 3'b000);
                5'b01_111: e.instr = b_type(bimm, rsp, 3'b001);
                5'b10_000: begin
                    e.instr   = i_type({27'd0, c[6:2]}, rd, 3'b001, rd, OPC_OP_IMM);
                    e.illegal = c[12];
                end
                5'b10_010: begin
                    e.instr   = i_type({24'd0, c[3:2], c[12], c[6:4], 2'b00}, 5'd2, 3'b010,
                                       rd, OPC_LOAD);
                    e.illegal = (rd == 5'd0);
                end
                5'b10_100: begin
                    if (c[6:2] != 5'd0)
                        // C.MV or C.ADD
                        e.instr = r_type(7'd0, c[6:2], c[12] ? rd : 5'd0, 3'b000, rd);
                    else if (c[12] && rd == 5'd0)
                        e.instr = 32'h0010_0073;
                    else
                        // C.JR or C.JALR
                        e.instr = i_type(32'd0, rd, 3'b000, {4'd0, c[12]}, OPC_JALR);
                    e.illegal = !c[12] && (c[6:2] == 5'd0) && (rd == 5'd0);
                end
                5'b10_110: e.instr = sw_word({24'd0, c[8:7], c[12:9], 2'b00}, c[6:2], 5'd2);
                // Reserved and floating-point slots
                default: e.illegal = 1'b1;
            endcase
        end
        return e;
    endfunction

    // Reference RV32I field split
    function automatic decoded_t model_decode(input expanded_t e);
        decoded_t    d;
        logic [31:0] w;
        w            = e.instr;
        d.opcode     = opcode_e'(w[6:0]);
        d.rd         = w[11:7];
        d.rs1        = w[19:15];
        d.rs2        = w[24:20];
        d.funct3     = w[14:12];
        d.funct7     = w[31:25];
        d.pc         = e.pc;
        d.next_pc    = e.pc + (e.compressed ? 32'd2 : 32'd4);
        d.compressed = e.compressed;
        d.illegal    = e.illegal;
        d.imm        = '0;
        case (w[6:0])
            OPC_LOAD, OPC_OP_IMM, OPC_JALR, OPC_SYSTEM: d.imm = {{20{w[31]}}, w[31:20]};
            OPC_STORE:  d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
            OPC_BRANCH: d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC: d.imm = {w[31:12], 12'd0};
            OPC_JAL:    d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            OPC_OP:     d.imm = '0;
            default:    d.illegal = 1'b1;
        endcase
        return d;
    endfunction

    task automatic stop_run(input string why);
        $display("*** FAILED ***");
        $fatal(1, "%s", why);
    endtask

    task automatic check_decoded(input decoded_t got, input decoded_t want);
        logic bad;
        // Illegal words only promise the flag, pc and next pc
        if (want.illegal)
            bad = (got.illegal !== 1'b1) || (got.compressed !== want.compressed) ||
                  (got.pc !== want.pc) || (got.next_pc !== want.next_pc);
        else
            bad = (got !== want);
        if (bad) begin
            $display("Fail time=%0t dec expected=%h actual=%h", $time, want, got);
            stop_run("decoded instruction differs from the model");
        end
    endtask

    task automatic check_next_pc(input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("Fail time=%0t next_pc expected=%h actual=%h", $time, want, got);
            stop_run("next pc differs from the model");
        end
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Bound properties count their failures
    always @(negedge clk) begin
        if (DUT.u_assert.fail_count != 0)
            stop_run("a bound assertion on the front end failed");
    end

    initial begin : stimulus
        logic [31:0] cls;
        logic [31:0] k;
        logic [31:0] instr;
        logic [31:0] pc;
        decoded_t    d;
        rst_n     = 1'b1;
        win_valid = 1'b0;
        win       = '0;
        lfsr      = 32'd51;
        pc        = `RVC_RESET_PC;
        // Falling reset edge once every process waits
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int n = 0; n < NUM_WIN; n++) begin
            // Occasional idle cycles
            if (rand_bits(2) == 0) begin
                repeat (rand_bits(2)) begin
                    @(posedge clk);
                    win_valid <= 1'b0;
                end
            end
            cls   = rand_bits(2);
            instr = rand_bits(32);
            if (cls != 3) begin
                // Class picks the quadrant, sometimes with zero operand bits
                instr[1:0] = cls[1:0];
                if (rand_bits(3) == 0)
                    instr[12:2] = '0;
            end else begin
                k = rand_bits(4);
                if (rand_bits(1) != 0)
                    instr[6:0] = LEGAL_OPS[k % 10];
                else
                    instr[1:0] = 2'b11;
            end
            d = model_decode(model_expand(instr, pc));
            @(posedge clk);
            win_valid <= 1'b1;
            // Memory byte 0 rides in the top lane
            win.data  <= {instr[7:0], instr[15:8], instr[23:16], instr[31:24]};
            win.pc    <= pc;
            exp_q.push_back(d);
            pc = d.next_pc;
        end
        @(posedge clk);
        win_valid <= 1'b0;
    end

    initial begin : check_outputs
        int       waited;
        decoded_t want;
        @(negedge clk);
        if (dec_valid)
            stop_run("decoded output during reset");
        check_next_pc(next_pc, `RVC_RESET_PC);
        for (int n = 0; n < NUM_WIN; n++) begin
            waited = 0;
            @(negedge clk);
            while (!dec_valid) begin
                if (waited == TIMEOUT)
                    stop_run("no decoded output within the timeout");
                waited++;
                @(negedge clk);
            end
            if (exp_q.size() == 0)
                stop_run("decoded output with no window in flight");
            want = exp_q.pop_front();
            check_decoded(dec, want);
            check_next_pc(next_pc, want.next_pc);
        end
        // Drained pipeline stays quiet
        repeat (8) begin
            @(negedge clk);
            if (dec_valid)
                stop_run("extra decoded output after the last window");
        end
        if (DUT.u_assert.fail_count != 0) begin
            stop_run("a bound assertion on the front end failed");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

// File: tb/rvc_frontend_assert.sv
// Concurrent checks on the front end output strobe, reset behaviour and pc increment
`timescale 1ns/1ns

module rvc_frontend_assert import rvc_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     win_valid,
    input logic     dec_valid,
    input decoded_t dec
);

    // Failed properties so far, watched by the testbench
    int unsigned fail_count = 0;

    // Every window leaves exactly three edges later
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        win_valid |-> ##3 dec_valid)
        else begin
            fail_count++;
            $error("window strobe without a decoded strobe three cycles later");
        end

    // No output unless a window went in three cycles back
    a_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid |-> $past(win_valid, 3))
        else begin
            fail_count++;
            $error("decoded strobe without a matching window strobe");
        end

    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !dec_valid)
        else begin
            fail_count++;
            $error("decoded strobe while in reset");
        end

    // Step of 2 only for compressed parcels
    a_incr_compressed: assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid |-> ((dec.next_pc - dec.pc == 32'd2) == dec.compressed))
        else begin
            fail_count++;
            $error("pc step does not match the compressed flag");
        end

endmodule

bind rvc_frontend rvc_frontend_assert u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .win_valid (win_valid),
    .dec_valid (dec_valid),
    .dec       (dec)
);

// File: src/rvc_frontend.sv
// RV32IC instruction front end, classify then expand then decode in three cycles
`timescale 1ns/1ns

module rvc_frontend import rvc_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        win_valid,
    input  fetch_win_t  win,
    output logic        dec_valid,
    output decoded_t    dec,
    output logic [31:0] next_pc
);

    // Stage 1 to 2
    logic      parcel_valid;
    parcel_t   parcel;
    // Stage 2 to 3
    logic      exp_valid;
    expanded_t exp;

    rvc_classify u_classify (
        .clk          (clk),
        .rst_n        (rst_n),
        .win_valid    (win_valid),
        .win          (win),
        .parcel_valid (parcel_valid),
        .parcel       (parcel)
    );

    rvc_expand u_expand (
        .clk          (clk),
        .rst_n        (rst_n),
        .parcel_valid (parcel_valid),
        .parcel       (parcel),
        .exp_valid    (exp_valid),
        .exp          (exp)
    );

    rv_field_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .exp_valid (exp_valid),
        .exp       (exp),
        .dec_valid (dec_valid),
        .dec       (dec),
        .next_pc   (next_pc)
    );

endmodule

// File: src/rv_field_decode.sv
// Stage 3, RV32I field split, immediate assembly, opcode class and next pc
`timescale 1ns/1ns
`include "rvc_config.svh"

module rv_field_decode import rvc_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        exp_valid,
    input  expanded_t   exp,
    output logic        dec_valid,
    output decoded_t    dec,
    output logic [31:0] next_pc
);

    logic [31:0] w;
    logic [31:0] imm;
    logic        known;
    logic [31:0] npc;

    assign w   = exp.instr;
    // Increment is 2 or 4 from stage 1
    assign npc = exp.pc + {29'd0, exp.incr};

    // Immediate by format, unknown opcodes flagged
    always_comb begin
        imm   = 32'h0;
        known = 1'b1;
        case (w[6:0])
            // I-type
            OPC_LOAD, OPC_OP_IMM, OPC_JALR, OPC_SYSTEM:
                imm = {{20{w[31]}}, w[31:20]};
            // S-type
            OPC_STORE:
                imm = {{20{w[31]}}, w[31:25], w[11:7]};
            // B-type, bit 0 always zero
            OPC_BRANCH:
                imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            // U-type
            OPC_LUI, OPC_AUIPC:
                imm = {w[31:12], 12'h000};
            // J-type
            OPC_JAL:
                imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            // Register ops carry no immediate
            OPC_OP:
                imm = 32'h0;
            default:
                known = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
            dec       <= '0;
            next_pc   <= `RVC_RESET_PC;
        end else begin
            dec_valid <= exp_valid;
            if (exp_valid) begin
                dec.opcode     <= opcode_e'(w[6:0]);
                dec.rd         <= w[11:7];
                dec.rs1        <= w[19:15];
                dec.rs2        <= w[24:20];
                dec.funct3     <= w[14:12];
                dec.funct7     <= w[31:25];
                dec.imm        <= imm;
                dec.pc         <= exp.pc;
                dec.next_pc    <= npc;
                dec.compressed <= exp.compressed;
                // Earlier stage flags plus unknown major opcode
                dec.illegal    <= exp.illegal | ~known;
                // Fetch-side copy, moves with the output strobe
                next_pc        <= npc;
            end
        end
    end

endmodule

// File: src/rvc_expand.sv
// Stage 2, expansion of RV32C parcels into equivalent RV32I instructions
`timescale 1ns/1ns

module rvc_expand import rvc_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      parcel_valid,
    input  parcel_t   parcel,
    output logic      exp_valid,
    output expanded_t exp
);

    rvc_parcel_u p;
    logic [31:0] x;
    logic        ill;
    logic [5:0]  imm6;
    logic [11:0] simm12;
    logic [4:0]  rdp;
    logic [4:0]  rs2p;
    logic [20:0] jimm;
    logic [12:0] bimm;

    // Three-bit register field covers x8..x15
    function automatic logic [4:0] creg(input logic [2:0] r);
        return {2'b01, r};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    // Compare against x0 only
    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd0, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // Low half is the parcel
    assign p      = parcel.instr[15:0];
    assign imm6   = {p.ci.imm_hi, p.ci.imm_lo};
    assign simm12 = {{6{imm6[5]}}, imm6};
    assign rdp    = creg(p.cb.rs1_p);
    assign rs2p   = creg(p.cs.rs2_p);
    // CJ scrambled offset
    assign jimm = {{9{p.cj.target[10]}}, p.cj.target[10], p.cj.target[6], p.cj.target[8:7],
                   p.cj.target[4], p.cj.target[5], p.cj.target[0], p.cj.target[9],
                   p.cj.target[3:1], 1'b0};
    // CB branch offset
    assign bimm = {{5{p.cb.off_hi[2]}}, p.cb.off_lo[4:3], p.cb.off_lo[0], p.cb.off_hi[1:0],
                   p.cb.off_lo[2:1], 1'b0};

    always_comb begin
        x   = parcel.instr;
        ill = parcel.illegal;
        if (parcel.compressed) begin
            x = 32'h0;
            if (!parcel.illegal) begin
                case ({p.cr.op, p.ci.funct3})
                    // C.ADDI4SPN, zero immediate reserved
                    5'b00_000: begin
                        x   = enc_i({2'b00, p.ciw.imm[5:2], p.ciw.imm[7:6], p.ciw.imm[0],
                                     p.ciw.imm[1], 2'b00}, 5'd2, 3'b000, creg(p.ciw.rd_p),
                                    OPC_OP_IMM);
                        ill = (p.ciw.imm == 8'h00);
                    end
                    // C.LW
                    5'b00_010: x = enc_i({5'd0, p.cl.imm_lo[0], p.cl.imm_hi, p.cl.imm_lo[1],
                                          2'b00}, creg(p.cl.rs1_p), 3'b010,
                                         creg(p.cl.rd_p), OPC_LOAD);
                    // C.SW
                    5'b00_110: x = {5'd0, p.cs.imm_lo[0], p.cs.imm_hi[2], rs2p,
                                    creg(p.cs.rs1_p), 3'b010, p.cs.imm_hi[1:0],
                                    p.cs.imm_lo[1], 2'b00, OPC_STORE};
                    // C.NOP / C.ADDI
                    5'b01_000: x = enc_i(simm12, p.ci.rd_rs1, 3'b000, p.ci.rd_rs1, OPC_OP_IMM);
                    // C.JAL links to x1
                    5'b01_001: x = enc_j(jimm, 5'd1);
                    // C.LI
                    5'b01_010: x = enc_i(simm12, 5'd0, 3'b000, p.ci.rd_rs1, OPC_OP_IMM);
                    5'b01_011: begin
                        if (p.ci.rd_rs1 == 5'd2) begin
                            // C.ADDI16SP
                            x = enc_i({{3{p.ci.imm_hi}}, p.ci.imm_lo[2:1], p.ci.imm_lo[3],
                                       p.ci.imm_lo[0], p.ci.imm_lo[4], 4'b0000}, 5'd2,
                                      3'b000, 5'd2, OPC_OP_IMM);
                        end else begin
                            // C.LUI
                            x = {{14{imm6[5]}}, imm6, p.ci.rd_rs1, OPC_LUI};
                        end
                        // Both reserve a zero immediate
                        ill = (imm6 == 6'd0);
                    end
                    5'b01_100: begin
                        case (p.cb.off_hi[1:0])
                            // C.SRLI, shamt[5] reserved on RV32
                            2'b00: begin
                                x   = {7'b0000000, imm6[4:0], rdp, 3'b101, rdp, OPC_OP_IMM};
                                ill = imm6[5];
                            end
                            // C.SRAI
                            2'b01: begin
                                x   = {7'b0100000, imm6[4:0], rdp, 3'b101, rdp, OPC_OP_IMM};
                                ill = imm6[5];
                            end
                            // C.ANDI
                            2'b10: x = enc_i(simm12, rdp, 3'b111, rdp, OPC_OP_IMM);
                            default: begin
                                // SUBW/ADDW group is RV64 only
                                ill = p.cs.imm_hi[2];
                                case (p.cs.imm_lo)
                                    2'b00: x = enc_r(7'b0100000, rs2p, rdp, 3'b000, rdp);
                                    2'b01: x = enc_r(7'b0000000, rs2p, rdp, 3'b100, rdp);
                                    2'b10: x = enc_r(7'b0000000, rs2p, rdp, 3'b110, rdp);
                                    default: x = enc_r(7'b0000000, rs2p, rdp, 3'b111, rdp);
                                endcase
                            end
                        endcase
                    end
                    // C.J, C.BEQZ, C.BNEZ
                    5'b01_101: x = enc_j(jimm, 5'd0);
                    5'b01_110: x = enc_b(bimm, rdp, 3'b000);
                    5'b01_111: x = enc_b(bimm, rdp, 3'b001);
                    // C.SLLI
                    5'b10_000: begin
                        x   = {7'b0000000, imm6[4:0], p.ci.rd_rs1, 3'b001, p.ci.rd_rs1,
                               OPC_OP_IMM};
                        ill = imm6[5];
                    end
                    // C.LWSP, rd x0 reserved
                    5'b10_010: begin
                        x   = enc_i({4'd0, p.ci.imm_lo[1:0], p.ci.imm_hi, p.ci.imm_lo[4:2],
                                     2'b00}, 5'd2, 3'b010, p.ci.rd_rs1, OPC_LOAD);
                        ill = (p.ci.rd_rs1 == 5'd0);
                    end
                    5'b10_100: begin
                        if (!p.cr.funct4[0]) begin
                            if (p.cr.rs2 == 5'd0) begin
                                // C.JR, rs1 x0 reserved
                                x   = enc_i(12'd0, p.cr.rd_rs1, 3'b000, 5'd0, OPC_JALR);
                                ill = (p.cr.rd_rs1 == 5'd0);
                            end else begin
                                // C.MV
                                x = enc_r(7'd0, p.cr.rs2, 5'd0, 3'b000, p.cr.rd_rs1);
                            end
                        end else if (p.cr.rs2 == 5'd0 && p.cr.rd_rs1 == 5'd0) begin
                            // C.EBREAK
                            x = 32'h0010_0073;
                        end else if (p.cr.rs2 == 5'd0) begin
                            // C.JALR links to x1
                            x = enc_i(12'd0, p.cr.rd_rs1, 3'b000, 5'd1, OPC_JALR);
                        end else begin
                            // C.ADD
                            x = enc_r(7'd0, p.cr.rs2, p.cr.rd_rs1, 3'b000, p.cr.rd_rs1);
                        end
                    end
                    // C.SWSP
                    5'b10_110: x = {4'd0, p.css.imm[1:0], p.css.imm[5], p.css.rs2, 5'd2,
                                    3'b010, p.css.imm[4:2], 2'b00, OPC_STORE};
                    // Reserved slots and FP loads/stores
                    default: ill = 1'b1;
                endcase
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_valid <= 1'b0;
            exp       <= '0;
        end else begin
            exp_valid <= parcel_valid;
            if (parcel_valid) begin
                exp.instr      <= x;
                exp.pc         <= parcel.pc;
                exp.compressed <= parcel.compressed;
                exp.illegal    <= ill;
                exp.incr       <= parcel.incr;
            end
        end
    end

endmodule

// File: src/rvc_classify.sv
// Stage 1, byte reorder of the fetch window and compressed/full-width classification
`timescale 1ns/1ns
`include "rvc_config.svh"

module rvc_classify import rvc_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       win_valid,
    input  fetch_win_t win,
    output logic       parcel_valid,
    output parcel_t    parcel
);

    logic [31:0] instr;
    logic        is_c;

    // Bus lane 31:24 is memory byte 0, so swap all four bytes
    assign instr = {win.data[7:0], win.data[15:8], win.data[23:16], win.data[31:24]};

    // Quadrants 0..2 are compressed, 11 means a full-width word
    assign is_c = (instr[1:0] != 2'b11);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            parcel_valid <= 1'b0;
            parcel       <= '0;
        end else begin
            // Strobe follows input every cycle
            parcel_valid <= win_valid;
            if (win_valid) begin
                parcel.instr      <= instr;
                parcel.pc         <= win.pc;
                parcel.compressed <= is_c;
                // Without C support any compressed parcel is illegal
                parcel.illegal    <= is_c & (`RVC_HAS_C == 1'b0);
                parcel.incr       <= is_c ? 3'd2 : 3'd4;
            end
        end
    end

endmodule

// File: src/rvc_pkg.sv
// RVC front end shared types: major opcodes, parcel formats and stage records
package rvc_pkg;

    // RV32I major opcodes seen by the decoder
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // One 16-bit parcel, viewed per RVC format
    typedef union packed {
        // Register form, also JR/MV/ADD
        struct packed {
            logic [3:0] funct4;
            logic [4:0] rd_rs1;
            logic [4:0] rs2;
            logic [1:0] op;
        } cr;
        // Immediate form
        struct packed {
            logic [2:0] funct3;
            logic       imm_hi;
            logic [4:0] rd_rs1;
            logic [4:0] imm_lo;
            logic [1:0] op;
        } ci;
        // Stack-relative store
        struct packed {
            logic [2:0] funct3;
            logic [5:0] imm;
            logic [4:0] rs2;
            logic [1:0] op;
        } css;
        // Wide immediate, ADDI4SPN only
        struct packed {
            logic [2:0] funct3;
            logic [7:0] imm;
            logic [2:0] rd_p;
            logic [1:0] op;
        } ciw;
        // Load
        struct packed {
            logic [2:0] funct3;
            logic [2:0] imm_hi;
            logic [2:0] rs1_p;
            logic [1:0] imm_lo;
            logic [2:0] rd_p;
            logic [1:0] op;
        } cl;
        // Store, and the arithmetic CA group
        struct packed {
            logic [2:0] funct3;
            logic [2:0] imm_hi;
            logic [2:0] rs1_p;
            logic [1:0] imm_lo;
            logic [2:0] rs2_p;
            logic [1:0] op;
        } cs;
        // Branch and shift/ANDI
        struct packed {
            logic [2:0] funct3;
            logic [2:0] off_hi;
            logic [2:0] rs1_p;
            logic [4:0] off_lo;
            logic [1:0] op;
        } cb;
        // Jump
        struct packed {
            logic [2:0]  funct3;
            logic [10:0] target;
            logic [1:0]  op;
        } cj;
    } rvc_parcel_u;

    // Raw fetch window, bus byte order
    typedef struct packed {
        logic [31:0] data;
        logic [31:0] pc;
    } fetch_win_t;

    // Stage 1 to stage 2
    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic        compressed;
        logic        illegal;
        logic [2:0]  incr;
    } parcel_t;

    // Stage 2 to stage 3
    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic        compressed;
        logic        illegal;
        logic [2:0]  incr;
    } expanded_t;

    // Decoded instruction out of the front end
    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [31:0] imm;
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic        compressed;
        logic        illegal;
    } decoded_t;

endpackage

// File: src/rvc_config.svh
// RVC front end build options for compressed support and reset program counter
`ifndef RVC_CONFIG_SVH
`define RVC_CONFIG_SVH

// Expand RV32C parcels when set, flag them illegal when cleared
`define RVC_HAS_C 1'b1

// Next-pc value held out of reset
`define RVC_RESET_PC 32'h0000_0000

`endif
